// ==== bgpu_frontend.f ====
+incdir+test
rtl/bgpu_pkg.sv
rtl/bgpu_warp_fetcher.sv
rtl/bgpu_inst_buffer.sv
rtl/bgpu_decoder.sv
rtl/bgpu_frontend.sv
test/tb_bgpu_frontend.sv

// ==== rtl/bgpu_decoder.sv ====
//####################################################################
// Instruction decoder
// Splits the buffered word into dispatch fields, resolves control
// instructions locally and reports the next PC of each warp
//####################################################################

module bgpu_decoder (
    // From the instruction buffer
    input  logic                  ibuf_valid_i,
    output logic                  ibuf_ready_o,
    input  bgpu_pkg::fetch_pkt_t  ibuf_pkt_i,

    // To dispatch
    output logic                  disp_valid_o,
    input  logic                  disp_ready_i,
    output bgpu_pkg::dec_pkt_t    disp_pkt_o,

    // Next PC back to the fetcher
    output logic                  pc_upd_valid_o,
    output bgpu_pkg::pc_upd_t     pc_upd_o
);
    import bgpu_pkg::*;

    enc_inst_u  enc;
    inst_t      inst;

    logic       is_stop;
    logic       is_jmp;
    logic       is_sync;
    logic       is_ctrl;

    logic [1:0] op_req;
    logic       branch;

    pc_t        pc_plus_one;
    pc_t        jmp_target;
    pc_t        next_pc;

    assign enc  = ibuf_pkt_i.inst;
    assign inst = enc.r.inst;

    assign is_stop = (enc.r.inst == StopOpcode);
    assign is_jmp  = (inst.eu == EU_BRU) && (inst.subtype == BRU_JMP);
    assign is_sync = (inst.eu == EU_BRU) && (inst.subtype == BRU_SYNC);

    // Control instructions never leave the decoder
    assign is_ctrl = is_stop || is_jmp || is_sync;

    // Bit 1 of op_req marks op1 as a register and bit 0 marks op0
    always_comb begin : decode
        op_req = 2'b00;
        branch = 1'b0;

        case (inst.eu)
            EU_IU: begin
                if (inst.subtype inside {IU_ADD, IU_SUB, IU_AND, IU_OR, IU_XOR, IU_SHL}) begin
                    op_req = 2'b11;
                end else if (inst.subtype inside {IU_ADDI, IU_SUBI, IU_SHLI}) begin
                    // op0 carries the immediate
                    op_req = 2'b10;
                end
            end
            EU_LSU: begin
                // Address and store data are both registers
                op_req = 2'b11;
            end
            EU_BRU: begin
                if (inst.subtype == BRU_BRANCH) begin
                    // Condition register in op1 and offset immediate in op0
                    op_req = 2'b10;
                    branch = 1'b1;
                end
            end
            default: begin
                op_req = 2'b00;
            end
        endcase
    end

    // Truncating the signed offset keeps the sign extension modulo the PC width
    assign pc_plus_one = ibuf_pkt_i.pc + pc_t'(1);
    assign jmp_target  = pc_plus_one + pc_t'(enc.o.offset);

    // Branches are not resolved here and fall through like sync
    assign next_pc = is_jmp ? jmp_target : pc_plus_one;

    assign disp_valid_o = ibuf_valid_i && !is_ctrl;
    assign ibuf_ready_o = is_ctrl || disp_ready_i;

    always_comb begin
        disp_pkt_o.wid    = ibuf_pkt_i.wid;
        disp_pkt_o.pc     = ibuf_pkt_i.pc;
        disp_pkt_o.inst   = inst;
        disp_pkt_o.dst    = enc.r.dst;
        disp_pkt_o.op1    = enc.r.op1;
        disp_pkt_o.op0    = enc.r.op0;
        disp_pkt_o.op_req = op_req;
        disp_pkt_o.branch = branch;
    end

    // One pulse per consumed instruction
    assign pc_upd_valid_o   = ibuf_valid_i && ibuf_ready_o;
    assign pc_upd_o.wid     = ibuf_pkt_i.wid;
    assign pc_upd_o.next_pc = next_pc;
    assign pc_upd_o.stop    = is_stop;

endmodule : bgpu_decoder

// ==== rtl/bgpu_frontend.sv ====
//####################################################################
// BGPU instruction front end
// Warp fetcher, instruction buffer and decoder of one compute unit
//####################################################################

module bgpu_frontend (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,

    input  logic                                 start_i,

    input  logic                                 imem_we_i,
    input  bgpu_pkg::pc_t                        imem_addr_i,
    input  logic [bgpu_pkg::EncInstWidth-1:0]    imem_data_i,

    output logic                                 disp_valid_o,
    input  logic                                 disp_ready_i,
    output bgpu_pkg::dec_pkt_t                   disp_pkt_o,

    output logic                                 done_o
);
    import bgpu_pkg::*;

    logic       fetch_valid;
    logic       fetch_ready;
    fetch_pkt_t fetch_pkt;

    logic       ibuf_valid;
    logic       ibuf_ready;
    fetch_pkt_t ibuf_pkt;

    logic       pc_upd_valid;
    pc_upd_t    pc_upd;

    bgpu_warp_fetcher fetcher0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .start_i        (start_i),
        .imem_we_i      (imem_we_i),
        .imem_addr_i    (imem_addr_i),
        .imem_data_i    (imem_data_i),
        .pc_upd_valid_i (pc_upd_valid),
        .pc_upd_i       (pc_upd),
        .fetch_valid_o  (fetch_valid),
        .fetch_ready_i  (fetch_ready),
        .fetch_pkt_o    (fetch_pkt),
        .done_o         (done_o)
    );

    bgpu_inst_buffer ibuf0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (fetch_valid),
        .in_ready_o  (fetch_ready),
        .in_pkt_i    (fetch_pkt),
        .out_valid_o (ibuf_valid),
        .out_ready_i (ibuf_ready),
        .out_pkt_o   (ibuf_pkt)
    );

    bgpu_decoder decoder0 (
        .ibuf_valid_i   (ibuf_valid),
        .ibuf_ready_o   (ibuf_ready),
        .ibuf_pkt_i     (ibuf_pkt),
        .disp_valid_o   (disp_valid_o),
        .disp_ready_i   (disp_ready_i),
        .disp_pkt_o     (disp_pkt_o),
        .pc_upd_valid_o (pc_upd_valid),
        .pc_upd_o       (pc_upd)
    );

endmodule : bgpu_frontend

// ==== rtl/bgpu_inst_buffer.sv ====
//####################################################################
// Instruction buffer
// Circular FIFO of fetch packets between fetcher and decoder
//####################################################################

module bgpu_inst_buffer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  bgpu_pkg::fetch_pkt_t  in_pkt_i,

    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output bgpu_pkg::fetch_pkt_t  out_pkt_o
);
    import bgpu_pkg::*;

    fetch_pkt_t              mem_q [IbufDepth];
    logic [IbufPtrWidth-1:0] rd_ptr_q;
    logic [IbufPtrWidth-1:0] wr_ptr_q;
    logic [IbufPtrWidth:0]   count_q;

    logic                    push;
    logic                    pop;

    assign out_valid_o = (count_q != '0);
    assign pop         = out_valid_o && out_ready_i;

    // Full buffer still takes a write when the head leaves this cycle
    assign in_ready_o  = (count_q != IbufDepth) || pop;
    assign push        = in_valid_i && in_ready_o;

    assign out_pkt_o   = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_pkt_i;
        end
    end

    count_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        count_q <= IbufDepth
    ) else $error("Instruction buffer count %0d above depth", count_q);

    // Head stays put while the decoder stalls it
    head_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pkt_o)
    ) else $error("Instruction buffer head changed while stalled");

endmodule : bgpu_inst_buffer

// ==== rtl/bgpu_pkg.sv ====
//####################################################################
// BGPU front end package
// Sizes, opcode encodings and the packets passed between fetcher,
// instruction buffer and decoder
//####################################################################

package bgpu_pkg;

    // Compute unit sizing
    localparam int unsigned NumWarps          = 4;
    localparam int unsigned WidWidth          = 2;
    localparam int unsigned PcWidth           = 8;
    localparam int unsigned ImemDepth         = 256;
    localparam int unsigned EncInstWidth      = 32;
    localparam int unsigned RegIdxWidth       = 8;

    // Instruction buffer
    localparam int unsigned IbufDepth         = 4;
    localparam int unsigned IbufPtrWidth      = $clog2(IbufDepth);

    // Warp w starts executing at w * WarpStartPcStride
    localparam int unsigned WarpStartPcStride = 64;

    // Full 8 bit opcode that stops a warp
    localparam logic [7:0]  StopOpcode        = 8'hFF;

    typedef logic [WidWidth-1:0]    wid_t;
    typedef logic [PcWidth-1:0]     pc_t;
    typedef logic [RegIdxWidth-1:0] reg_idx_t;

    // Execution unit, upper nibble of the opcode
    typedef enum logic [3:0] {
        EU_IU   = 4'h0,
        EU_LSU  = 4'h1,
        EU_BRU  = 4'h2,
        EU_CTRL = 4'h3
    } eu_e;

    // Subtype, lower nibble of the opcode
    typedef enum logic [3:0] {
        IU_ADD     = 4'h0,
        IU_SUB     = 4'h1,
        IU_AND     = 4'h2,
        IU_OR      = 4'h3,
        IU_XOR     = 4'h4,
        IU_SHL     = 4'h5,
        IU_ADDI    = 4'h6,
        IU_SUBI    = 4'h7,
        IU_SHLI    = 4'h8,
        BRU_JMP    = 4'h9,
        BRU_SYNC   = 4'hA,
        BRU_BRANCH = 4'hB
    } subtype_e;

    typedef struct packed {
        eu_e      eu;
        subtype_e subtype;
    } inst_t;

    // Register view: destination and two operand fields
    typedef struct packed {
        inst_t    inst;
        reg_idx_t dst;
        reg_idx_t op1;
        reg_idx_t op0;
    } enc_reg_t;

    // Offset view: the low 16 bits form one signed jump offset
    typedef struct packed {
        inst_t              inst;
        reg_idx_t           dst;
        logic signed [15:0] offset;
    } enc_off_t;

    typedef union packed {
        enc_reg_t r;
        enc_off_t o;
    } enc_inst_u;

    // Fetcher to buffer to decoder
    typedef struct packed {
        wid_t      wid;
        pc_t       pc;
        enc_inst_u inst;
    } fetch_pkt_t;

    // Decoder to dispatch
    typedef struct packed {
        wid_t       wid;
        pc_t        pc;
        inst_t      inst;
        reg_idx_t   dst;
        reg_idx_t   op1;
        reg_idx_t   op0;
        logic [1:0] op_req;
        logic       branch;
    } dec_pkt_t;

    // Decoder to fetcher
    typedef struct packed {
        wid_t wid;
        pc_t  next_pc;
        logic stop;
    } pc_upd_t;

endpackage : bgpu_pkg

// ==== rtl/bgpu_warp_fetcher.sv ====
//####################################################################
// Warp fetcher
// Per-warp PC table with round-robin selection, instruction memory
// and a fetch register holding one packet towards the buffer
//####################################################################

module bgpu_warp_fetcher (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,

    input  logic                                 start_i,

    // Instruction memory load port
    input  logic                                 imem_we_i,
    input  bgpu_pkg::pc_t                        imem_addr_i,
    input  logic [bgpu_pkg::EncInstWidth-1:0]    imem_data_i,

    // Next PC from the decoder
    input  logic                                 pc_upd_valid_i,
    input  bgpu_pkg::pc_upd_t                    pc_upd_i,

    // To the instruction buffer
    output logic                                 fetch_valid_o,
    input  logic                                 fetch_ready_i,
    output bgpu_pkg::fetch_pkt_t                 fetch_pkt_o,

    output logic                                 done_o
);
    import bgpu_pkg::*;

    logic [EncInstWidth-1:0] imem_q [ImemDepth];

    pc_t                     pc_q [NumWarps];
    logic [NumWarps-1:0]     active_q;
    logic [NumWarps-1:0]     waiting_q;
    logic [NumWarps-1:0]     eligible;
    wid_t                    rr_q;
    logic                    started_q;

    logic                    fetch_valid_q;
    fetch_pkt_t              fetch_q;

    logic                    sel_found;
    wid_t                    sel_wid;
    logic                    fetch_load;

    // A warp may be fetched only when nothing of it is in flight
    assign eligible = active_q & ~waiting_q;

    // Round-robin search starting at the pointer
    always_comb begin : rr_select
        wid_t cand;
        sel_found = 1'b0;
        sel_wid   = rr_q;
        for (int i = 0; i < NumWarps; i++) begin
            cand = rr_q + wid_t'(i);
            if (!sel_found && eligible[cand]) begin
                sel_found = 1'b1;
                sel_wid   = cand;
            end
        end
    end

    // Load the fetch register when it is empty or drains this cycle
    assign fetch_load = sel_found && (!fetch_valid_q || fetch_ready_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q      <= '0;
            waiting_q     <= '0;
            rr_q          <= '0;
            started_q     <= 1'b0;
            fetch_valid_q <= 1'b0;
        end else begin
            if (start_i) begin
                active_q  <= '1;
                waiting_q <= '0;
                started_q <= 1'b1;
            end else begin
                if (fetch_load) begin
                    waiting_q[sel_wid] <= 1'b1;
                    rr_q               <= sel_wid + wid_t'(1);
                end
                // Selected and updated warps never coincide
                if (pc_upd_valid_i) begin
                    waiting_q[pc_upd_i.wid] <= 1'b0;
                    if (pc_upd_i.stop) begin
                        active_q[pc_upd_i.wid] <= 1'b0;
                    end
                end
            end

            if (fetch_load) begin
                fetch_valid_q <= 1'b1;
            end else if (fetch_ready_i) begin
                fetch_valid_q <= 1'b0;
            end
        end
    end

    // PC table
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            for (int w = 0; w < NumWarps; w++) begin
                pc_q[w] <= pc_t'(w * WarpStartPcStride);
            end
        end else if (pc_upd_valid_i && !pc_upd_i.stop) begin
            pc_q[pc_upd_i.wid] <= pc_upd_i.next_pc;
        end
    end

    // Instruction memory with synchronous read into the fetch register
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem_q[imem_addr_i] <= imem_data_i;
        end
        if (fetch_load) begin
            fetch_q.wid  <= sel_wid;
            fetch_q.pc   <= pc_q[sel_wid];
            fetch_q.inst <= imem_q[pc_q[sel_wid]];
        end
    end

    assign fetch_valid_o = fetch_valid_q;
    assign fetch_pkt_o   = fetch_q;

    assign done_o = started_q && (active_q == '0);

    // The decoder only answers for warps that have an instruction in flight
    upd_for_waiting_warp: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pc_upd_valid_i |-> waiting_q[pc_upd_i.wid]
    ) else $error("PC update for warp %0d without a fetch in flight", pc_upd_i.wid);

endmodule : bgpu_warp_fetcher

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the front end testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_bgpu_frontend \
    -f bgpu_frontend.f > "$log" 2>&1 \
    && ./obj_dir/Vtb_bgpu_frontend >> "$log" 2>&1 \
    || { cat "$log"; echo "Build or simulation did not complete, see $log"; exit 1; }

cat "$log"
grep -q "Simulation failed" "$log" && { echo "FAIL"; exit 1; }
echo "PASS"

// ==== test/tb_programs.svh ====
//####################################################################
// Warp programs for the front end testbench
// Instruction memory image and the start PC of each warp
//####################################################################

`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Columns: 8-bit imem address, then the word {opcode, dst, op1, op0}
logic [39:0] prog_table [31] = '{
    // Warp 0, forward jump over three words
    {8'd0,   32'h00_03_01_02},   // Add r3, r1, r2
    {8'd1,   32'h06_04_03_05},   // Addi r4, r3, 5
    {8'd2,   32'h29_00_00_03},   // Jmp +3 to 6
    {8'd3,   32'h00_0F_0F_0F},   // Skipped
    {8'd4,   32'h01_0F_0F_0F},   // Skipped
    {8'd5,   32'h02_0F_0F_0F},   // Skipped
    {8'd6,   32'h10_05_04_03},   // Load/store r5, r4, r3
    {8'd7,   32'hFF_00_00_00},   // Stop
    // Warp 1, sync and branch fall through
    {8'd64,  32'h01_01_02_03},   // Sub r1, r2, r3
    {8'd65,  32'h2A_00_00_00},   // Sync
    {8'd66,  32'h2B_00_07_04},   // Branch on r7
    {8'd67,  32'h29_00_00_02},   // Jmp +2 to 70
    {8'd68,  32'h03_0E_0E_0E},   // Skipped
    {8'd69,  32'h04_0E_0E_0E},   // Skipped
    {8'd70,  32'h04_02_01_01},   // Xor r2, r1, r1
    {8'd71,  32'hFF_00_00_00},   // Stop
    // Warp 2, jump forward then back
    {8'd128, 32'h29_00_00_04},   // Jmp +4 to 133
    {8'd129, 32'h08_06_06_03},   // Shli r6, r6, 3
    {8'd130, 32'hFF_00_00_00},   // Stop
    {8'd131, 32'h00_0D_0D_0D},   // Skipped
    {8'd132, 32'h05_0D_0D_0D},   // Skipped
    {8'd133, 32'h03_06_01_02},   // Or r6, r1, r2
    {8'd134, 32'h29_00_FF_FA},   // Jmp -6 to 129
    // Warp 3, straight line
    {8'd192, 32'h02_07_05_06},   // And r7, r5, r6
    {8'd193, 32'h05_08_07_01},   // Shl r8, r7, r1
    {8'd194, 32'h07_09_08_02},   // Subi r9, r8, 2
    {8'd195, 32'h2B_00_09_10},   // Branch on r9
    {8'd196, 32'h10_0A_09_08},   // Load/store r10, r9, r8
    {8'd197, 32'h2A_00_00_00},   // Sync
    {8'd198, 32'h06_0B_0A_01},   // Addi r11, r10, 1
    {8'd199, 32'hFF_00_00_00}    // Stop
};

// Warp w starts at w * 64
pc_t start_pc_table [NumWarps] = '{8'd0, 8'd64, 8'd128, 8'd192};

`endif

// ==== test/tb_bgpu_frontend.sv ====
//####################################################################
// BGPU front end testbench
// Loads warp programs and checks every dispatch against a reference
// walk of the programs under random dispatch back-pressure
//####################################################################

module tb_bgpu_frontend;
    timeunit 1ns;
    timeprecision 100ps;

    import bgpu_pkg::*;

    `include "tb_programs.svh"

    // Tag 1 follows a jump, tag 2 follows a sync or branch
    typedef struct packed {
        logic [1:0] tag;
        dec_pkt_t   pkt;
    } exp_entry_t;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic                    imem_we;
    pc_t                     imem_addr;
    logic [EncInstWidth-1:0] imem_data;
    logic                    disp_valid;
    logic                    disp_ready;
    dec_pkt_t                disp_pkt;
    logic                    done;

    logic [EncInstWidth-1:0] ref_mem [ImemDepth];
    logic                    ref_loaded [ImemDepth];
    exp_entry_t              exp_q [NumWarps][$];

    // Index 0 to 4 follows behaviors 1 to 5
    int                      checks [5];
    int                      errs [5];
    int                      total_expected;
    int                      dispatched;
    int                      cycle_count;
    int                      cycle_limit;
    logic                    running;
    logic [31:0]             lfsr;

    bgpu_frontend dut0 (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .imem_we_i    (imem_we),
        .imem_addr_i  (imem_addr),
        .imem_data_i  (imem_data),
        .disp_valid_o (disp_valid),
        .disp_ready_i (disp_ready),
        .disp_pkt_o   (disp_pkt),
        .done_o       (done)
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Register bits {op1, op0} and the branch flag of a dispatched opcode
    function automatic logic [2:0] operand_kinds(input logic [7:0] op);
        if (op[7:4] == EU_LSU) begin
            return 3'b110;
        end else if (op == {EU_BRU, BRU_BRANCH}) begin
            return 3'b101;
        end else if (op[7:4] == EU_IU && op[3:0] <= IU_SHL) begin
            return 3'b110;
        end else if (op[7:4] == EU_IU && op[3:0] <= IU_SHLI) begin
            return 3'b100;
        end
        return 3'b000;
    endfunction

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] exp, input int beh);
        checks[beh]++;
        if (got !== exp) begin
            errs[beh]++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Walks each warp from its start PC and queues what it must dispatch
    task automatic build_expected();
        pc_t         pc;
        logic [31:0] word;
        logic [1:0]  tag;
        exp_entry_t  e;
        int          steps;
        logic        stopped;
        for (int w = 0; w < NumWarps; w++) begin
            pc      = start_pc_table[w];
            tag     = 2'd0;
            stopped = 1'b0;
            steps   = 0;
            while (!stopped) begin
                if (!ref_loaded[pc] || steps == ImemDepth) begin
                    $display("Reference walk of warp %0d left its program at pc %0d", w, pc);
                    errs[3]++;
                    stopped = 1'b1;
                end else begin
                    word = ref_mem[pc];
                    if (word[31:24] == StopOpcode) begin
                        stopped = 1'b1;
                    end else if (word[31:24] == {EU_BRU, BRU_JMP}) begin
                        // Offset counts from the following instruction
                        pc  = pc_t'(int'(pc) + 1 + int'($signed(word[15:0])));
                        tag = 2'd1;
                    end else if (word[31:24] == {EU_BRU, BRU_SYNC}) begin
                        pc  = pc + pc_t'(1);
                        tag = 2'd2;
                    end else begin
                        e.tag      = tag;
                        e.pkt.wid  = wid_t'(w);
                        e.pkt.pc   = pc;
                        e.pkt.inst = inst_t'(word[31:24]);
                        e.pkt.dst  = word[23:16];
                        e.pkt.op1  = word[15:8];
                        e.pkt.op0  = word[7:0];
                        {e.pkt.op_req, e.pkt.branch} = operand_kinds(word[31:24]);
                        exp_q[w].push_back(e);
                        total_expected++;
                        tag = e.pkt.branch ? 2'd2 : 2'd0;
                        pc  = pc + pc_t'(1);
                    end
                end
                steps++;
            end
        end
    endtask

    task automatic take_dispatch();
        exp_entry_t e;
        int         w;
        logic [7:0] op;
        w  = int'(disp_pkt.wid);
        op = disp_pkt.inst;
        compare("control opcode on dispatch",
                32'(op == StopOpcode || op == {EU_BRU, BRU_JMP} || op == {EU_BRU, BRU_SYNC}),
                32'd0, 2);
        if (exp_q[w].size() == 0) begin
            $display("ERROR at %0t ns: warp %0d dispatched pc %0d with nothing left to expect",
                     $time, w, disp_pkt.pc);
            errs[3]++;
        end else begin
            e = exp_q[w].pop_front();
            compare("pc", 32'(disp_pkt.pc), 32'(e.pkt.pc), 0);
            compare("opcode", 32'(disp_pkt.inst), 32'(e.pkt.inst), 0);
            compare("dst", 32'(disp_pkt.dst), 32'(e.pkt.dst), 0);
            compare("op1", 32'(disp_pkt.op1), 32'(e.pkt.op1), 0);
            compare("op0", 32'(disp_pkt.op0), 32'(e.pkt.op0), 0);
            compare("operand register bits", 32'(disp_pkt.op_req), 32'(e.pkt.op_req), 0);
            compare("branch flag", 32'(disp_pkt.branch), 32'(e.pkt.branch), 0);
            if (e.tag == 2'd1) begin
                compare("pc after jump", 32'(disp_pkt.pc), 32'(e.pkt.pc), 1);
            end else if (e.tag == 2'd2) begin
                compare("pc after sync or branch", 32'(disp_pkt.pc), 32'(e.pkt.pc), 2);
            end
            dispatched++;
        end
    endtask

    task automatic report();
        string names [5];
        int    total_checks;
        int    total_errs;
        names = '{"dispatch fields per warp", "jump targets", "control kept off dispatch",
                  "no loss or duplication", "done and quiet after done"};
        for (int w = 0; w < NumWarps; w++) begin
            compare($sformatf("packets left for warp %0d", w), 32'(exp_q[w].size()), 32'd0, 3);
        end
        compare("dispatch count", 32'(dispatched), 32'(total_expected), 3);
        total_checks = 0;
        total_errs   = 0;
        for (int b = 0; b < 5; b++) begin
            if (checks[b] == 0) begin
                $display("Behavior %0d made no checks at all", b + 1);
                errs[b]++;
            end
            $display("Behavior %0d, %s: %0d checks, %0d errors",
                     b + 1, names[b], checks[b], errs[b]);
            total_checks += checks[b];
            total_errs   += errs[b];
        end
        $display("Totals: %0d checks, %0d errors, %0d of %0d packets dispatched",
                 total_checks, total_errs, dispatched, total_expected);
        if (total_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
    endtask

    // Random back-pressure and the cycle counter
    always @(posedge clk) begin
        if (running) begin
            lfsr = lfsr_step(lfsr);
            disp_ready  <= lfsr[0];
            cycle_count <= cycle_count + 1;
        end
    end

    always @(negedge clk) begin
        if (running && done) begin
            compare("dispatch valid after done", 32'(disp_valid), 32'd0, 4);
        end
        if (running && disp_valid && disp_ready) begin
            take_dispatch();
        end
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        start          = 1'b0;
        imem_we        = 1'b0;
        imem_addr      = '0;
        imem_data      = '0;
        disp_ready     = 1'b0;
        running        = 1'b0;
        lfsr           = 32'h142c;
        cycle_count    = 0;
        total_expected = 0;
        dispatched     = 0;
        for (int b = 0; b < 5; b++) begin
            checks[b] = 0;
            errs[b]   = 0;
        end
        for (int a = 0; a < ImemDepth; a++) begin
            ref_loaded[a] = 1'b0;
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare("done_o after reset", 32'(done), 32'd0, 4);

        foreach (prog_table[i]) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= prog_table[i][39:32];
            imem_data <= prog_table[i][31:0];
            ref_mem[prog_table[i][39:32]]    = prog_table[i][31:0];
            ref_loaded[prog_table[i][39:32]] = 1'b1;
        end
        @(posedge clk);
        imem_we <= 1'b0;

        build_expected();
        cycle_limit = 20 * total_expected + 200;

        @(posedge clk);
        start   <= 1'b1;
        running <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;

        while (!done && cycle_count < cycle_limit) begin
            @(negedge clk);
        end
        if (!done) begin
            $display("Timeout: done_o did not rise within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end else begin
            // Watch a while longer for dispatches after done
            repeat (20) @(negedge clk);
            report();
            $finish;
        end
    end

endmodule : tb_bgpu_frontend
